/* list.f */
logic/kbc_pkg.sv
logic/kbc_fifo.sv
logic/ps2_rx.sv
logic/kbc_cmd.sv
logic/kbc_output.sv
logic/kbc_top.sv
bench/kbc_assertions.sv
bench/kbc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := kbc_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/kbc_tb.sv */
// ------------------------------
// keyboard model holds each ps2 clock half-phase for 40 system cycles
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module kbc_tb
    import kbc_pkg::*;
();

    logic       clk = 1'b0;
    logic       rst_n;
    kbc_bus_t   bus;
    logic [7:0] rdata;
    logic       irq_keyb;
    logic       a20_enable;
    logic       ps2_kbclk;
    logic       ps2_kbdat;
    logic       ps2_kbclk_out;
    int         test_errors = 0;
    int         error_count = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    kbc_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (bus),
        .rdata         (rdata),
        .irq_keyb      (irq_keyb),
        .a20_enable    (a20_enable),
        .ps2_kbclk     (ps2_kbclk),
        .ps2_kbdat     (ps2_kbdat),
        .ps2_kbclk_out (ps2_kbclk_out)
    );

    always #10 clk = ~clk;

    // ------------------------------
    // checks and bus tasks
    // ------------------------------
    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s: expected %h got %h", $time, name, exp, got);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        error_count += test_errors;
        test_errors = 0;
    endtask

    task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
        @(posedge clk);
        bus <= '{rd: 1'b0, wr: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        bus <= '0;
    endtask

    task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
        @(posedge clk);
        bus <= '{rd: 1'b1, wr: 1'b0, addr: addr, wdata: 8'h00};
        @(posedge clk);
        bus <= '0;
        @(negedge clk);
        data = rdata;                                   // settled after the read edge
    endtask

    task automatic wait_status(input logic [7:0] mask, output logic [7:0] st);
        int n;
        st = 8'h00;
        for (n = 0; n < 200; n++) begin
            bus_read(kbc_addr_cmd, st);
            if ((st & mask) != 8'h00) break;
            repeat (20) @(posedge clk);
        end
        if ((st & mask) == 8'h00) begin
            $display("timeout waiting for status mask %h at t=%0t", mask, $time);
            test_errors++;
        end
    endtask

    task automatic wait_line(input bit a20_line, input logic level);
        logic seen;
        int   n;
        seen = a20_line ? a20_enable : ps2_kbclk_out;
        for (n = 0; n < 100 && seen !== level; n++) begin
            @(negedge clk);
            seen = a20_line ? a20_enable : ps2_kbclk_out;
        end
        if (seen !== level) begin
            $display("timeout waiting for %s to reach %b",
                     a20_line ? "a20_enable" : "ps2_kbclk_out", level);
            test_errors++;
        end
    endtask

    // start, 8 data lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] data, input bit bad_parity);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_kbdat <= bits[i];
            repeat (40) @(posedge clk);
            ps2_kbclk <= 1'b0;
            repeat (40) @(posedge clk);
            ps2_kbclk <= 1'b1;
        end
    endtask

    task automatic receive_and_check(input logic [7:0] data, input logic irq_exp);
        logic [7:0] st;
        logic [7:0] got;
        send_frame(data, 1'b0);
        wait_status(8'h01, st);
        check_value("irq_keyb", 8'(irq_keyb), 8'(irq_exp));
        bus_read(kbc_addr_data, got);
        check_value("rdata", got, data);
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [7:0] sent [3];
        logic [7:0] st;
        logic [7:0] got;
        logic [7:0] p;
        void'($urandom(32'h62503d27));
        rst_n     <= 1'b0;
        bus       <= '0;
        ps2_kbclk <= 1'b1;
        ps2_kbdat <= 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        check_value("irq_keyb", 8'(irq_keyb), 8'h00);
        check_value("a20_enable", 8'(a20_enable), 8'h01);
        check_value("ps2_kbclk_out", 8'(ps2_kbclk_out), 8'h01);
        check_value("rdata", rdata, 8'h00);
        bus_read(kbc_addr_cmd, st);
        check_value("status", st, 8'h18);
        end_test("reset");

        for (int i = 0; i < 3; i++) begin
            sent[i] = 8'($urandom);
            send_frame(sent[i], 1'b0);
        end
        wait_status(8'h01, st);
        check_value("irq_keyb", 8'(irq_keyb), 8'h01);
        for (int i = 0; i < 3; i++) begin
            bus_read(kbc_addr_data, got);
            check_value("rdata", got, sent[i]);
        end
        bus_read(kbc_addr_cmd, st);
        check_value("status", st, 8'h18);
        end_test("receive");

        send_frame(8'($urandom), 1'b1);
        wait_status(8'h80, st);
        check_value("status", st, 8'h98);               // flag set, nothing queued
        bus_read(kbc_addr_cmd, st);
        check_value("status", st, 8'h18);
        end_test("parity error");

        bus_write(kbc_addr_cmd, 8'h60);
        bus_write(kbc_addr_data, 8'h00);
        bus_write(kbc_addr_cmd, 8'h20);
        wait_status(8'h01, st);
        bus_read(kbc_addr_data, got);
        check_value("command byte", got, 8'h00);
        receive_and_check(8'($urandom), 1'b0);
        bus_write(kbc_addr_cmd, 8'h60);
        bus_write(kbc_addr_data, 8'h01);
        receive_and_check(8'($urandom), 1'b1);
        end_test("command byte");

        send_frame(8'($urandom), 1'b0);                // left queued for the flush
        wait_status(8'h01, st);
        bus_write(kbc_addr_cmd, 8'hAA);
        wait_status(8'h01, st);
        bus_read(kbc_addr_data, got);
        check_value("self test", got, kbc_self_test_ok);
        bus_read(kbc_addr_cmd, st);
        check_value("status", st, 8'h1C);
        bus_write(kbc_addr_cmd, 8'hAB);
        wait_status(8'h01, st);
        bus_read(kbc_addr_data, got);
        check_value("interface test", got, 8'h00);
        p = 8'($urandom);
        bus_write(kbc_addr_cmd, 8'hD2);
        bus_write(kbc_addr_data, p);
        wait_status(8'h01, st);
        bus_read(kbc_addr_data, got);
        check_value("d2 echo", got, p);
        end_test("self test and replies");

        bus_write(kbc_addr_cmd, 8'hAD);
        wait_line(1'b0, 1'b0);
        bus_write(kbc_addr_cmd, 8'hAE);
        wait_line(1'b0, 1'b1);
        receive_and_check(8'($urandom), 1'b1);
        bus_write(kbc_addr_cmd, 8'hDD);
        wait_line(1'b1, 1'b0);
        bus_write(kbc_addr_cmd, 8'hDF);
        wait_line(1'b1, 1'b1);
        end_test("inhibit and a20");

        error_count += u_dut.u_assertions.assert_fails;
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/kbc_assertions.sv */
// ------------------------------
// bound into kbc_top; reaches into u_out for fifo and parity state
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module kbc_assertions
    import kbc_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input kbc_bus_t   bus,
    input kbc_cfg_t   cfg,
    input kbc_byte_t  reply,
    input logic       fifo_high,
    input logic       fifo_empty,
    input logic       parity_err,
    input logic [7:0] rdata,
    input logic       irq_keyb,
    input logic       ps2_kbclk_out
);

    logic status_rd;
    logic self_test_wr;
    int   assert_fails = 0;

    assign status_rd    = bus.rd && (bus.addr == kbc_addr_cmd);
    assign self_test_wr = bus.wr && (bus.addr == kbc_addr_cmd) && (bus.wdata == 8'hAA);

    irq_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        irq_keyb |-> $past(cfg.allow_irq))                  // irq is registered
        else begin
            $error("irq_keyb high without allow_irq");
            assert_fails++;
        end

    // inhibit only entered after the cause was seen in idle
    inhibit_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
        !ps2_kbclk_out |-> (cfg.disable_kb || fifo_high)
            && $past(cfg.disable_kb || fifo_high))
        else begin
            $error("keyboard clock held low without a cause");
            assert_fails++;
        end

    status_layout: assert property (@(posedge clk) disable iff (!rst_n)
        status_rd |=> (rdata[6:4] == 3'b001) && !rdata[1]
            && (rdata[7] == $past(parity_err)) && (rdata[3] == $past(cfg.cmd_last))
            && (rdata[2] == $past(cfg.system_flag)) && (rdata[0] == !$past(fifo_empty)))
        else begin
            $error("status byte does not match its fields");
            assert_fails++;
        end

    self_test_reply: assert property (@(posedge clk) disable iff (!rst_n)
        self_test_wr |=> fifo_empty && reply.valid && (reply.data == kbc_self_test_ok))
        else begin
            $error("self test did not flush the fifo and reply 0x55");
            assert_fails++;
        end

    self_test_still_empty: assert property (@(posedge clk) disable iff (!rst_n)
        $past(self_test_wr, 2) |-> fifo_empty)
        else begin
            $error("fifo filled before the self test reply");
            assert_fails++;
        end

    self_test_written: assert property (@(posedge clk) disable iff (!rst_n)
        $past(self_test_wr, 3) |-> !fifo_empty)
        else begin
            $error("self test reply never reached the fifo");
            assert_fails++;
        end

endmodule

bind kbc_top kbc_assertions u_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus           (bus),
    .cfg           (cfg),
    .reply         (reply),
    .fifo_high     (fifo_high),
    .fifo_empty    (u_out.fifo_empty),
    .parity_err    (u_out.parity_err),
    .rdata         (rdata),
    .irq_keyb      (irq_keyb),
    .ps2_kbclk_out (ps2_kbclk_out)
);

`default_nettype wire

/* logic/kbc_top.sv */
// ------------------------------
// keyboard channel only; bus strobes are single cycle
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module kbc_top
    import kbc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  kbc_bus_t   bus,
    output logic [7:0] rdata,
    output logic       irq_keyb,
    output logic       a20_enable,
    input  logic       ps2_kbclk,
    input  logic       ps2_kbdat,
    output logic       ps2_kbclk_out
);

    kbc_cfg_t  cfg;
    kbc_byte_t rx_byte;
    kbc_byte_t reply;
    logic      rx_parity_err;
    logic      fifo_clear;
    logic      fifo_high;

    ps2_rx u_rx (
        .clk           (clk),
        .rst_n         (rst_n),
        .ps2_kbclk     (ps2_kbclk),
        .ps2_kbdat     (ps2_kbdat),
        .cfg           (cfg),
        .fifo_high     (fifo_high),
        .ps2_kbclk_out (ps2_kbclk_out),
        .rx_byte       (rx_byte),
        .rx_parity_err (rx_parity_err)
    );

    kbc_cmd u_cmd (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .cfg        (cfg),
        .a20_enable (a20_enable),
        .reply      (reply),
        .fifo_clear (fifo_clear)
    );

    kbc_output u_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (bus),
        .cfg           (cfg),
        .rx_byte       (rx_byte),
        .rx_parity_err (rx_parity_err),
        .reply         (reply),
        .fifo_clear    (fifo_clear),
        .fifo_high     (fifo_high),
        .rdata         (rdata),
        .irq_keyb      (irq_keyb)
    );

endmodule

`default_nettype wire

/* logic/kbc_output.sv */
// ------------------------------
// one held reply only; a newer reply overwrites it
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module kbc_output
    import kbc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  kbc_bus_t  bus,
    input  kbc_cfg_t  cfg,
    input  kbc_byte_t rx_byte,
    input  logic      rx_parity_err,
    input  kbc_byte_t reply,
    input  logic      fifo_clear,
    output logic      fifo_high,
    output logic [7:0] rdata,
    output logic      irq_keyb
);

    logic                 status_rd;
    logic                 data_rd;
    logic                 held_valid;
    logic [7:0]           held_data;
    logic                 reply_avail;
    logic                 reply_go;
    logic                 wr_valid;
    logic [7:0]           wr_data;
    logic                 parity_err;
    logic [7:0]           status;
    logic [7:0]           last_q;
    logic [7:0]           fifo_q;
    logic                 fifo_empty;
    logic [kbc_fifo_aw:0] fifo_count;

    assign status_rd   = bus.rd && (bus.addr == kbc_addr_cmd);
    assign data_rd     = bus.rd && (bus.addr == kbc_addr_data);
    assign fifo_high   = (fifo_count >= kbc_fifo_high_water);
    assign reply_avail = reply.valid || held_valid;
    assign reply_go    = reply_avail && !rx_byte.valid && !fifo_high;   // receiver goes first

    // ------------------------------
    // fifo write staging
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_valid   <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            wr_valid   <= !fifo_clear && (rx_byte.valid || reply_go);   // self test flushes
            held_valid <= reply_avail && !reply_go;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_byte.valid) begin
            wr_data <= rx_byte.data;
        end else if (reply.valid) begin
            wr_data <= reply.data;
        end else begin
            wr_data <= held_data;
        end
        if (reply.valid) held_data <= reply.data;
    end

    kbc_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (fifo_clear),
        .wr    (wr_valid),
        .wdata (wr_data),
        .rd    (data_rd),
        .q     (fifo_q),
        .empty (fifo_empty),
        .count (fifo_count)
    );

    // ------------------------------
    // status and host reads
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            parity_err <= 1'b0;
        end else if (rx_parity_err) begin
            parity_err <= 1'b1;
        end else if (status_rd) begin
            parity_err <= 1'b0;
        end
    end

    assign status = {parity_err, 2'b00, 1'b1, cfg.cmd_last, cfg.system_flag, 1'b0, !fifo_empty};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata    <= 8'h00;
            last_q   <= 8'h00;
            irq_keyb <= 1'b0;
        end else begin
            if (status_rd) begin
                rdata <= status;
            end else if (data_rd) begin
                rdata <= fifo_empty ? last_q : fifo_q;   // empty read repeats last byte
            end
            if (data_rd && !fifo_empty) last_q <= fifo_q;
            irq_keyb <= cfg.allow_irq && !fifo_empty && !data_rd;   // drops for one cycle per read
        end
    end

endmodule

`default_nettype wire

/* logic/kbc_cmd.sv */
// ------------------------------
// data port writes without a pending parameter are ignored
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module kbc_cmd
    import kbc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  kbc_bus_t  bus,
    output kbc_cfg_t  cfg,
    output logic      a20_enable,
    output kbc_byte_t reply,
    output logic      fifo_clear
);

    logic        cmd_wr;
    logic        data_wr;
    logic        param_wr;
    logic        param_pending;
    kbc_opcode_e opcode;
    kbc_opcode_e param_op;
    logic        reply_cmd;
    logic [7:0]  cmd_image;
    logic        reply_valid;
    logic [7:0]  reply_data;

    assign cmd_wr    = bus.wr && (bus.addr == kbc_addr_cmd);
    assign data_wr   = bus.wr && (bus.addr == kbc_addr_data);
    assign opcode    = kbc_opcode_e'(bus.wdata);
    assign param_wr  = data_wr && param_pending;
    assign reply_cmd = cmd_wr && (opcode == OP_READ_CMD || opcode == OP_SELF_TEST ||
                                  opcode == OP_IF_TEST);

    // bit 6 translate and bit 5 mouse are not kept
    assign cmd_image  = {3'b000, cfg.disable_kb, 1'b0, cfg.system_flag, 1'b0, cfg.allow_irq};
    assign fifo_clear = cmd_wr && (opcode == OP_SELF_TEST);   // one cycle ahead of the reply
    assign a20_enable = cfg.a20;

    // ------------------------------
    // parameter tracking
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            param_pending <= 1'b0;
            param_op      <= OP_WRITE_CMD;
        end else if (cmd_wr) begin
            param_pending <= (opcode == OP_WRITE_CMD) || (opcode == OP_WRITE_KB_OUT);
            param_op      <= opcode;                 // also cancels a pending one
        end else if (data_wr) begin
            param_pending <= 1'b0;
        end
    end

    // ------------------------------
    // command byte and a20
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.disable_kb  <= 1'b0;
            cfg.system_flag <= 1'b0;
            cfg.allow_irq   <= 1'b1;
            cfg.cmd_last    <= 1'b1;
            cfg.a20         <= 1'b1;
        end else begin
            if (cmd_wr) begin
                cfg.cmd_last <= 1'b1;
            end else if (data_wr) begin
                cfg.cmd_last <= 1'b0;
            end

            if (param_wr && param_op == OP_WRITE_CMD) begin
                cfg.disable_kb  <= bus.wdata[4];
                cfg.system_flag <= bus.wdata[2];
                cfg.allow_irq   <= bus.wdata[0];
            end

            if (cmd_wr) begin
                case (opcode)
                    OP_SELF_TEST:  cfg.system_flag <= 1'b1;
                    OP_KB_DISABLE: cfg.disable_kb  <= 1'b1;
                    OP_KB_ENABLE:  cfg.disable_kb  <= 1'b0;
                    OP_A20_OFF:    cfg.a20         <= 1'b0;
                    OP_A20_ON:     cfg.a20         <= 1'b1;
                    default:       ;
                endcase
            end
        end
    end

    // ------------------------------
    // replies
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reply_valid <= 1'b0;
        end else begin
            reply_valid <= reply_cmd || (param_wr && param_op == OP_WRITE_KB_OUT);
        end
    end

    always_ff @(posedge clk) begin
        if (param_wr) begin
            reply_data <= bus.wdata;                 // d2 echoes its parameter
        end else if (cmd_wr) begin
            case (opcode)
                OP_READ_CMD:  reply_data <= cmd_image;
                OP_SELF_TEST: reply_data <= kbc_self_test_ok;
                OP_IF_TEST:   reply_data <= 8'h00;   // no clock or data faults
                default:      ;
            endcase
        end
    end

    assign reply.valid = reply_valid;
    assign reply.data  = reply_data;

endmodule

`default_nettype wire

/* logic/ps2_rx.sv */
// ------------------------------
// keyboard to host frames only; no timeout, a stuck frame waits for the lines
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ps2_rx
    import kbc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ps2_kbclk,
    input  logic      ps2_kbdat,
    input  kbc_cfg_t  cfg,
    input  logic      fifo_high,
    output logic      ps2_kbclk_out,
    output kbc_byte_t rx_byte,
    output logic      rx_parity_err
);

    logic                      kbclk_s;
    logic                      kbdat_s;
    logic [kbc_clk_window-1:0] clk_hist;
    logic                      edge_wait;
    logic                      fall_edge;
    rx_state_e                 state;
    logic [3:0]                bit_cnt;
    logic                      parity;
    logic                      parity_ok;
    logic [7:0]                shift;
    logic                      inhibit_req;
    logic                      frame_done;

    // ------------------------------
    // synchronizer and edge filter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kbclk_s <= 1'b1;
            kbdat_s <= 1'b1;
        end else begin
            kbclk_s <= ps2_kbclk;
            kbdat_s <= ps2_kbdat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_hist  <= '1;
            edge_wait <= 1'b0;
            fall_edge <= 1'b0;
        end else begin
            clk_hist  <= {clk_hist[kbc_clk_window-2:0], kbclk_s};
            fall_edge <= 1'b0;
            if (!edge_wait && (&clk_hist[kbc_clk_window-1 -: 4]) && !(|clk_hist[3:0])) begin
                fall_edge <= 1'b1;
                edge_wait <= 1'b1;                   // one edge per low phase
            end else if (edge_wait && !(|clk_hist)) begin
                edge_wait <= 1'b0;                   // line low long enough, re-arm
            end
        end
    end

    // ------------------------------
    // frame fsm
    // ------------------------------
    assign inhibit_req = cfg.disable_kb | fifo_high;
    assign frame_done  = (state == RX_WAIT_IDLE) && kbclk_s && kbdat_s;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            bit_cnt   <= 4'd0;
            parity    <= 1'b0;
            parity_ok <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (inhibit_req) begin
                        state <= RX_INHIBIT;
                    end else if (fall_edge && !kbdat_s) begin   // start bit
                        state   <= RX_BITS;
                        bit_cnt <= 4'd0;
                        parity  <= 1'b0;
                    end
                end
                RX_INHIBIT: begin
                    if (!inhibit_req) state <= RX_IDLE;
                end
                RX_BITS: begin
                    if (fall_edge) begin
                        if (bit_cnt == 4'd8) begin
                            parity_ok <= parity ^ kbdat_s;      // odd parity over 9 bits
                            state     <= RX_WAIT_STOP;
                        end else begin
                            parity  <= parity ^ kbdat_s;
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                RX_WAIT_STOP: begin
                    if (fall_edge && kbdat_s) state <= RX_WAIT_IDLE;
                end
                RX_WAIT_IDLE: begin
                    if (kbclk_s && kbdat_s) state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_BITS && fall_edge && bit_cnt != 4'd8) begin
            shift <= {kbdat_s, shift[7:1]};                     // lsb first
        end
    end

    assign rx_byte.valid  = frame_done && parity_ok;
    assign rx_byte.data   = shift;
    assign rx_parity_err  = frame_done && !parity_ok;
    assign ps2_kbclk_out  = !((state == RX_INHIBIT) && inhibit_req);   // 0 pulls clock low

endmodule

`default_nettype wire

/* logic/kbc_fifo.sv */
// ------------------------------
// show-ahead byte fifo; overflow writes and underflow reads are dropped
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module kbc_fifo
    import kbc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 wr,
    input  logic [7:0]           wdata,
    input  logic                 rd,
    output logic [7:0]           q,
    output logic                 empty,
    output logic [kbc_fifo_aw:0] count
);

    logic [7:0]             mem [kbc_fifo_depth];
    logic [kbc_fifo_aw-1:0] wr_ptr;
    logic [kbc_fifo_aw-1:0] rd_ptr;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign full  = count[kbc_fifo_aw];     // count == depth
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;
    assign q     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // wraps
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/kbc_pkg.sv */
// ------------------------------
// shared types and sizing for the keyboard controller
// fifo depth must stay a power of two
// ------------------------------
`default_nettype none

package kbc_pkg;

    // ------------------------------
    // sizing and port map
    // ------------------------------
    localparam int kbc_fifo_depth = 64;
    localparam int kbc_fifo_aw    = 6;
    localparam logic [kbc_fifo_aw:0] kbc_fifo_high_water = 7'd60;  // inhibit and hold replies
    localparam int kbc_clk_window = 16;                              // edge filter history

    localparam logic [2:0] kbc_addr_data = 3'd0;
    localparam logic [2:0] kbc_addr_cmd  = 3'd4;   // command on write, status on read

    localparam logic [7:0] kbc_self_test_ok = 8'h55;

    // ------------------------------
    // structs
    // ------------------------------
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic [2:0] addr;
        logic [7:0] wdata;
    } kbc_bus_t;

    typedef struct packed {
        logic disable_kb;
        logic system_flag;
        logic allow_irq;
        logic cmd_last;     // last host write hit the command port
        logic a20;
    } kbc_cfg_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } kbc_byte_t;

    // ------------------------------
    // enums
    // ------------------------------
    typedef enum logic [7:0] {
        OP_READ_CMD     = 8'h20,
        OP_WRITE_CMD    = 8'h60,
        OP_SELF_TEST    = 8'hAA,
        OP_IF_TEST      = 8'hAB,
        OP_KB_DISABLE   = 8'hAD,
        OP_KB_ENABLE    = 8'hAE,
        OP_WRITE_KB_OUT = 8'hD2,
        OP_A20_OFF      = 8'hDD,
        OP_A20_ON       = 8'hDF
    } kbc_opcode_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_INHIBIT,
        RX_BITS,
        RX_WAIT_STOP,
        RX_WAIT_IDLE
    } rx_state_e;

endpackage

`default_nettype wire
